// File: verilog/axi_pkg.sv
package axi_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W   = 4;
  // Top ID bit on the slave side carries the master index
  localparam int IDS_W  = ID_W + 1;
  localparam int LEN_W  = 4;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } ar_m_t;

  typedef struct packed {
    logic [IDS_W-1:0]  id;
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } ar_s_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    resp_e             resp;
    logic              last;
  } r_m_t;

  typedef struct packed {
    logic [IDS_W-1:0]  id;
    logic [DATA_W-1:0] data;
    resp_e             resp;
    logic              last;
  } r_s_t;

  // One-hot R arbiter lock
  typedef enum logic [3:0] {
    LOCK_NO = 4'b0001,
    LOCK_S0 = 4'b0010,
    LOCK_S1 = 4'b0100,
    LOCK_S2 = 4'b1000
  } r_lock_e;

  typedef enum logic [1:0] {
    SEL_S0,
    SEL_S1,
    SEL_DEF
  } slave_sel_e;

  typedef enum logic {
    SEL_M0,
    SEL_M1
  } master_sel_e;

  function automatic master_sel_e ids_master(logic [IDS_W-1:0] id);
    return master_sel_e'(id[IDS_W-1]);
  endfunction

endpackage

// File: verilog/ar_router.sv
module ar_router #(
  parameter logic [axi_pkg::ADDR_W-1:0] S0_BASE     = 32'h0000_0000,
  parameter logic [axi_pkg::ADDR_W-1:0] S1_BASE     = 32'h0001_0000,
  parameter int                         REGION_BITS = 16
) (
  input  logic            clk,
  input  logic            rstn,
  // Masters
  input  axi_pkg::ar_m_t  m0_ar,
  input  axi_pkg::ar_m_t  m1_ar,
  input  logic            m0_arvalid,
  input  logic            m1_arvalid,
  output logic            m0_arready,
  output logic            m1_arready,
  // Slaves
  output axi_pkg::ar_s_t  s_ar,
  output logic            s0_arvalid,
  output logic            s1_arvalid,
  output logic            sd_arvalid,
  input  logic            s0_arready,
  input  logic            s1_arready,
  input  logic            sd_arready
);

  logic                 grant_vld_q;
  axi_pkg::master_sel_e grant_q;
  axi_pkg::master_sel_e sel_m;
  axi_pkg::ar_m_t       sel_ar;
  axi_pkg::slave_sel_e  slv;
  logic                 sel_valid;
  logic                 sel_ready;

  // A held grant wins over the fixed m0 priority
  always_comb begin
    if (grant_vld_q) begin
      sel_m = grant_q;
    end else if (m0_arvalid) begin
      sel_m = axi_pkg::SEL_M0;
    end else if (m1_arvalid) begin
      sel_m = axi_pkg::SEL_M1;
    end else begin
      sel_m = axi_pkg::SEL_M0;
    end
  end

  assign sel_ar    = (sel_m == axi_pkg::SEL_M1) ? m1_ar : m0_ar;
  assign sel_valid = (sel_m == axi_pkg::SEL_M1) ? m1_arvalid : m0_arvalid;

  // Address region decode
  always_comb begin
    if (sel_ar.addr[axi_pkg::ADDR_W-1:REGION_BITS] == S0_BASE[axi_pkg::ADDR_W-1:REGION_BITS]) begin
      slv = axi_pkg::SEL_S0;
    end else if (sel_ar.addr[axi_pkg::ADDR_W-1:REGION_BITS] ==
                 S1_BASE[axi_pkg::ADDR_W-1:REGION_BITS]) begin
      slv = axi_pkg::SEL_S1;
    end else begin
      slv = axi_pkg::SEL_DEF;
    end
  end

  always_comb begin
    case (slv)
      axi_pkg::SEL_S0: sel_ready = s0_arready;
      axi_pkg::SEL_S1: sel_ready = s1_arready;
      default:         sel_ready = sd_arready;
    endcase
  end

  assign s0_arvalid = sel_valid && (slv == axi_pkg::SEL_S0);
  assign s1_arvalid = sel_valid && (slv == axi_pkg::SEL_S1);
  assign sd_arvalid = sel_valid && (slv == axi_pkg::SEL_DEF);

  assign m0_arready = (sel_m == axi_pkg::SEL_M0) && sel_ready;
  assign m1_arready = (sel_m == axi_pkg::SEL_M1) && sel_ready;

  // Master index goes on top of the ID
  assign s_ar = '{id: {sel_m, sel_ar.id}, addr: sel_ar.addr, len: sel_ar.len};

  // Keep the grant while the request waits on arready
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      grant_vld_q <= 1'b0;
      grant_q     <= axi_pkg::SEL_M0;
    end else begin
      grant_vld_q <= sel_valid && !sel_ready;
      grant_q     <= sel_m;
    end
  end

  a_one_slave_arvalid: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({s0_arvalid, s1_arvalid, sd_arvalid}));

  // A waiting request stays on the slave bus unchanged
  a_req_held: assert property (@(posedge clk) disable iff (!rstn)
    (sel_valid && !sel_ready) |=> (sel_valid && $stable(s_ar)));

endmodule

// File: verilog/r_router.sv
module r_router (
  input  logic           clk,
  input  logic           rstn,
  // Slaves
  input  axi_pkg::r_s_t  s0_r,
  input  axi_pkg::r_s_t  s1_r,
  input  axi_pkg::r_s_t  sd_r,
  input  logic           s0_rvalid,
  input  logic           s1_rvalid,
  input  logic           sd_rvalid,
  output logic           s0_rready,
  output logic           s1_rready,
  output logic           sd_rready,
  // Masters
  output axi_pkg::r_m_t  m0_r,
  output axi_pkg::r_m_t  m1_r,
  output logic           m0_rvalid,
  output logic           m1_rvalid,
  input  logic           m0_rready,
  input  logic           m1_rready
);

  axi_pkg::r_lock_e     lock_q;
  axi_pkg::r_lock_e     lock_d;
  axi_pkg::r_lock_e     src;
  axi_pkg::r_s_t        sel_r;
  axi_pkg::r_m_t        m_beat;
  axi_pkg::master_sel_e dst;
  logic                 sel_valid;
  logic                 m_ready;
  logic                 hs;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lock_q <= axi_pkg::LOCK_NO;
    end else begin
      lock_q <= lock_d;
    end
  end

  // Fixed priority picks the source slave when unlocked
  always_comb begin
    src = lock_q;
    if (lock_q == axi_pkg::LOCK_NO) begin
      if (s0_rvalid) begin
        src = axi_pkg::LOCK_S0;
      end else if (s1_rvalid) begin
        src = axi_pkg::LOCK_S1;
      end else if (sd_rvalid) begin
        src = axi_pkg::LOCK_S2;
      end
    end
  end

  always_comb begin
    sel_r     = s0_r;
    sel_valid = 1'b0;
    case (src)
      axi_pkg::LOCK_S0: begin
        sel_r     = s0_r;
        sel_valid = s0_rvalid;
      end
      axi_pkg::LOCK_S1: begin
        sel_r     = s1_r;
        sel_valid = s1_rvalid;
      end
      axi_pkg::LOCK_S2: begin
        sel_r     = sd_r;
        sel_valid = sd_rvalid;
      end
      default: ;
    endcase
  end

  assign dst     = axi_pkg::ids_master(sel_r.id);
  assign m_ready = (dst == axi_pkg::SEL_M1) ? m1_rready : m0_rready;
  assign hs      = sel_valid && m_ready;

  // Only the owning slave sees the master's ready
  assign s0_rready = (src == axi_pkg::LOCK_S0) && m_ready;
  assign s1_rready = (src == axi_pkg::LOCK_S1) && m_ready;
  assign sd_rready = (src == axi_pkg::LOCK_S2) && m_ready;

  assign m_beat = '{id:   sel_r.id[axi_pkg::ID_W-1:0],
                    data: sel_r.data,
                    resp: sel_r.resp,
                    last: sel_r.last};

  assign m0_r      = m_beat;
  assign m1_r      = m_beat;
  assign m0_rvalid = sel_valid && (dst == axi_pkg::SEL_M0);
  assign m1_rvalid = sel_valid && (dst == axi_pkg::SEL_M1);

  // Rotate s0 -> s1 -> s2 -> s0 after each accepted beat
  always_comb begin
    lock_d = lock_q;
    case (lock_q)
      axi_pkg::LOCK_NO: begin
        lock_d = (sel_valid && !m_ready) ? src : axi_pkg::LOCK_NO;
      end
      axi_pkg::LOCK_S0: begin
        if (hs) begin
          lock_d = s1_rvalid ? axi_pkg::LOCK_S1 :
                   sd_rvalid ? axi_pkg::LOCK_S2 : axi_pkg::LOCK_NO;
        end
      end
      axi_pkg::LOCK_S1: begin
        if (hs) begin
          lock_d = sd_rvalid ? axi_pkg::LOCK_S2 :
                   s0_rvalid ? axi_pkg::LOCK_S0 : axi_pkg::LOCK_NO;
        end
      end
      axi_pkg::LOCK_S2: begin
        if (hs) begin
          lock_d = s0_rvalid ? axi_pkg::LOCK_S0 :
                   s1_rvalid ? axi_pkg::LOCK_S1 : axi_pkg::LOCK_NO;
        end
      end
      default: lock_d = axi_pkg::LOCK_NO;
    endcase
  end

  a_one_slave_rready: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0({s0_rready, s1_rready, sd_rready}));

  // A beat waiting on its master keeps its slave and its contents
  a_beat_held: assert property (@(posedge clk) disable iff (!rstn)
    (sel_valid && !m_ready) |=> (sel_valid && src == $past(src) && $stable(sel_r)));

endmodule

// File: verilog/decerr_slave.sv
module decerr_slave (
  input  logic           clk,
  input  logic           rstn,
  input  axi_pkg::ar_s_t ar,
  input  logic           arvalid,
  output logic           arready,
  output axi_pkg::r_s_t  r,
  output logic           rvalid,
  input  logic           rready
);

  logic                      busy_q;
  logic [axi_pkg::IDS_W-1:0] id_q;
  logic [axi_pkg::LEN_W-1:0] len_q;
  logic [axi_pkg::LEN_W-1:0] cnt_q;
  logic                      last;

  assign arready = !busy_q;
  assign rvalid  = busy_q;
  assign last    = (cnt_q == len_q);

  assign r = '{id:   id_q,
               data: '0,
               resp: axi_pkg::DECERR,
               last: last};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_q <= 1'b0;
    end else if (arvalid && arready) begin
      busy_q <= 1'b1;
    end else if (rvalid && rready && last) begin
      busy_q <= 1'b0;
    end
  end

  // Burst bookkeeping
  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      id_q  <= ar.id;
      len_q <= ar.len;
      cnt_q <= '0;
    end else if (rvalid && rready) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Beat count never runs past the final beat
  a_cnt_in_burst: assert property (@(posedge clk) disable iff (!rstn)
    rvalid |-> (cnt_q <= len_q));

endmodule

// File: verilog/axi_read_bus.sv
module axi_read_bus #(
  parameter logic [axi_pkg::ADDR_W-1:0] S0_BASE     = 32'h0000_0000,
  parameter logic [axi_pkg::ADDR_W-1:0] S1_BASE     = 32'h0001_0000,
  parameter int                         REGION_BITS = 16
) (
  input  logic           clk,
  input  logic           rstn,
  // Masters
  input  axi_pkg::ar_m_t m0_ar,
  input  axi_pkg::ar_m_t m1_ar,
  input  logic           m0_arvalid,
  input  logic           m1_arvalid,
  output logic           m0_arready,
  output logic           m1_arready,
  output axi_pkg::r_m_t  m0_r,
  output axi_pkg::r_m_t  m1_r,
  output logic           m0_rvalid,
  output logic           m1_rvalid,
  input  logic           m0_rready,
  input  logic           m1_rready,
  // External slaves
  output axi_pkg::ar_s_t s_ar,
  output logic           s0_arvalid,
  output logic           s1_arvalid,
  input  logic           s0_arready,
  input  logic           s1_arready,
  input  axi_pkg::r_s_t  s0_r,
  input  axi_pkg::r_s_t  s1_r,
  input  logic           s0_rvalid,
  input  logic           s1_rvalid,
  output logic           s0_rready,
  output logic           s1_rready
);

  // Default slave channel
  logic          sd_arvalid;
  logic          sd_arready;
  axi_pkg::r_s_t sd_r;
  logic          sd_rvalid;
  logic          sd_rready;

  ar_router #(
    .S0_BASE    (S0_BASE),
    .S1_BASE    (S1_BASE),
    .REGION_BITS(REGION_BITS)
  ) ar_router_i (
    .clk       (clk),
    .rstn      (rstn),
    .m0_ar     (m0_ar),
    .m1_ar     (m1_ar),
    .m0_arvalid(m0_arvalid),
    .m1_arvalid(m1_arvalid),
    .m0_arready(m0_arready),
    .m1_arready(m1_arready),
    .s_ar      (s_ar),
    .s0_arvalid(s0_arvalid),
    .s1_arvalid(s1_arvalid),
    .sd_arvalid(sd_arvalid),
    .s0_arready(s0_arready),
    .s1_arready(s1_arready),
    .sd_arready(sd_arready)
  );

  decerr_slave decerr_slave_i (
    .clk    (clk),
    .rstn   (rstn),
    .ar     (s_ar),
    .arvalid(sd_arvalid),
    .arready(sd_arready),
    .r      (sd_r),
    .rvalid (sd_rvalid),
    .rready (sd_rready)
  );

  r_router r_router_i (
    .clk      (clk),
    .rstn     (rstn),
    .s0_r     (s0_r),
    .s1_r     (s1_r),
    .sd_r     (sd_r),
    .s0_rvalid(s0_rvalid),
    .s1_rvalid(s1_rvalid),
    .sd_rvalid(sd_rvalid),
    .s0_rready(s0_rready),
    .s1_rready(s1_rready),
    .sd_rready(sd_rready),
    .m0_r     (m0_r),
    .m1_r     (m1_r),
    .m0_rvalid(m0_rvalid),
    .m1_rvalid(m1_rvalid),
    .m0_rready(m0_rready),
    .m1_rready(m1_rready)
  );

endmodule

// File: testbench/tb_axi_slave_model.sv
module tb_axi_slave_model #(
  parameter logic [31:0] KEY = 32'h1111_0000
) (
  input  logic           clk,
  input  logic           rstn,
  input  axi_pkg::ar_s_t ar,
  input  logic           arvalid,
  output logic           arready,
  output axi_pkg::r_s_t  r,
  output logic           rvalid,
  input  logic           rready,
  input  logic           stall
);

  axi_pkg::ar_s_t req_q = '0;
  logic           live_q = 1'b0;
  logic           stall_q = 1'b0;
  logic           ar_hs = 1'b0;
  logic           r_hs = 1'b0;
  logic           busy;
  logic [3:0]     beat;

  // Handshakes are seen on the rising edge
  always @(posedge clk) begin
    live_q  <= rstn;
    stall_q <= stall;
    ar_hs   <= rstn && arvalid && arready;
    r_hs    <= rstn && rvalid && rready;
    if (arvalid && arready) begin
      req_q <= ar;
    end
  end

  // Outputs change on the falling edge only
  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    r       = '0;
    busy    = 1'b0;
    beat    = '0;
    forever begin
      @(negedge clk);
      if (live_q !== 1'b1) begin
        busy    = 1'b0;
        beat    = '0;
        arready = 1'b0;
        rvalid  = 1'b0;
      end else begin
        if (ar_hs) begin
          busy = 1'b1;
          beat = '0;
        end else if (r_hs) begin
          if (beat == req_q.len) begin
            busy = 1'b0;
          end else begin
            beat = beat + 1'b1;
          end
        end
        arready = !busy;
        // A shown beat stays until taken
        if (!rvalid || r_hs) begin
          rvalid = busy && !stall_q;
        end
      end
      r = '{id:   req_q.id,
            data: (req_q.addr + 32'({beat, 2'b00})) ^ KEY,
            resp: axi_pkg::OKAY,
            last: (beat == req_q.len)};
    end
  end

endmodule

// File: testbench/tb_axi_read_bus.sv
module tb_axi_read_bus;

  localparam logic [31:0] S0_BASE = 32'h0000_0000;
  localparam logic [31:0] S1_BASE = 32'h0001_0000;
  localparam logic [31:0] S0_KEY  = 32'h1111_0000;
  localparam logic [31:0] S1_KEY  = 32'h2222_0000;
  localparam int BEATS = 1 + 8 + 16 + 4 + 24;
  localparam int REQS  = 1 + 1 + 2 + 1 + 3;
  localparam int WATCHDOG_CYCLES = (BEATS + REQS) * 40;

  logic           clk;
  logic           rstn;
  axi_pkg::ar_m_t m0_ar, m1_ar;
  logic           m0_arvalid, m1_arvalid, m0_arready, m1_arready;
  axi_pkg::r_m_t  m0_r, m1_r;
  logic           m0_rvalid, m1_rvalid, m0_rready, m1_rready;
  axi_pkg::ar_s_t s_ar;
  logic           s0_arvalid, s1_arvalid, s0_arready, s1_arready;
  axi_pkg::r_s_t  s0_r, s1_r;
  logic           s0_rvalid, s1_rvalid, s0_rready, s1_rready;
  logic           s0_stall, s1_stall;

  axi_pkg::r_m_t  m0_exp[$];
  axi_pkg::r_m_t  m1_exp[$];
  string          cur_test;
  logic           rand_mode;
  logic [31:0]    lfsr = 32'he697;
  int             value_errors = 0;
  int             other_errors = 0;

  axi_read_bus #(
    .S0_BASE    (S0_BASE),
    .S1_BASE    (S1_BASE),
    .REGION_BITS(16)
  ) axi_read_bus_i (
    .clk(clk), .rstn(rstn),
    .m0_ar(m0_ar), .m1_ar(m1_ar),
    .m0_arvalid(m0_arvalid), .m1_arvalid(m1_arvalid),
    .m0_arready(m0_arready), .m1_arready(m1_arready),
    .m0_r(m0_r), .m1_r(m1_r),
    .m0_rvalid(m0_rvalid), .m1_rvalid(m1_rvalid),
    .m0_rready(m0_rready), .m1_rready(m1_rready),
    .s_ar(s_ar),
    .s0_arvalid(s0_arvalid), .s1_arvalid(s1_arvalid),
    .s0_arready(s0_arready), .s1_arready(s1_arready),
    .s0_r(s0_r), .s1_r(s1_r),
    .s0_rvalid(s0_rvalid), .s1_rvalid(s1_rvalid),
    .s0_rready(s0_rready), .s1_rready(s1_rready)
  );

  tb_axi_slave_model #(.KEY(S0_KEY)) slave0_i (
    .clk(clk), .rstn(rstn), .ar(s_ar), .arvalid(s0_arvalid), .arready(s0_arready),
    .r(s0_r), .rvalid(s0_rvalid), .rready(s0_rready), .stall(s0_stall)
  );

  tb_axi_slave_model #(.KEY(S1_KEY)) slave1_i (
    .clk(clk), .rstn(rstn), .ar(s_ar), .arvalid(s1_arvalid), .arready(s1_arready),
    .r(s1_r), .rvalid(s1_rvalid), .rready(s1_rready), .stall(s1_stall)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] galois_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function logic rand_bit();
    lfsr = galois_step(lfsr);
    return lfsr[0];
  endfunction

  // Master ready and slave stalls are random only in back-pressure tests
  initial begin
    logic take;
    m0_rready = 1'b1;
    m1_rready = 1'b1;
    s0_stall  = 1'b0;
    s1_stall  = 1'b0;
    forever begin
      @(posedge clk);
      take = rand_mode;
      @(negedge clk);
      if (take) begin
        m0_rready = rand_bit();
        m1_rready = rand_bit();
        s0_stall  = rand_bit();
        s1_stall  = rand_bit();
      end else begin
        m0_rready = 1'b1;
        m1_rready = 1'b1;
        s0_stall  = 1'b0;
        s1_stall  = 1'b0;
      end
    end
  end

  task automatic compare_r_m(input string name, input axi_pkg::r_m_t exp,
                             input axi_pkg::r_m_t got);
    if (got !== exp) begin
      $display("Fail %s: expected id %h data %h last %b, actual id %h data %h last %b",
               name, exp.id, exp.data, exp.last, got.id, got.data, got.last);
      value_errors++;
    end
  endtask

  task automatic compare_resp(input string name, input axi_pkg::resp_e exp,
                              input axi_pkg::resp_e got);
    if (got !== exp) begin
      $display("Fail %s: expected resp %s, actual resp %b", name, exp.name(), got);
      value_errors++;
    end
  endtask

  task automatic compare_logic(input string name, input string sig, input logic exp,
                               input logic got);
    if (got !== exp) begin
      $display("Fail %s: %s expected %b, actual %b", name, sig, exp, got);
      value_errors++;
    end
  endtask

  task automatic check_beat(input bit m, input axi_pkg::r_m_t got);
    axi_pkg::r_m_t exp;
    if ((m && m1_exp.size() == 0) || (!m && m0_exp.size() == 0)) begin
      $display("Error in %s: master %0d received a beat nobody asked for", cur_test, m);
      other_errors++;
    end else begin
      if (m) begin
        exp = m1_exp.pop_front();
      end else begin
        exp = m0_exp.pop_front();
      end
      compare_resp(cur_test, exp.resp, got.resp);
      compare_r_m(cur_test, exp, got);
    end
  endtask

  // Collectors
  always @(posedge clk) begin
    if (rstn && m0_rvalid && m0_rready) begin
      check_beat(1'b0, m0_r);
    end
    if (rstn && m1_rvalid && m1_rready) begin
      check_beat(1'b1, m1_r);
    end
  end

  task automatic push_expected(input bit m, input logic [3:0] id, input logic [31:0] addr,
                               input logic [3:0] len, input logic [31:0] key,
                               input bit decerr);
    axi_pkg::r_m_t b;
    for (int k = 0; k <= int'(len); k++) begin
      b.id   = id;
      b.data = decerr ? 32'h0 : ((addr + 32'(4 * k)) ^ key);
      b.resp = decerr ? axi_pkg::DECERR : axi_pkg::OKAY;
      b.last = (k == int'(len));
      if (m) begin
        m1_exp.push_back(b);
      end else begin
        m0_exp.push_back(b);
      end
    end
  endtask

  task automatic send_ar(input bit m, input logic [3:0] id, input logic [31:0] addr,
                         input logic [3:0] len);
    logic ready;
    if (m) begin
      m1_ar      = '{id: id, addr: addr, len: len};
      m1_arvalid = 1'b1;
    end else begin
      m0_ar      = '{id: id, addr: addr, len: len};
      m0_arvalid = 1'b1;
    end
    do begin
      @(posedge clk);
      ready = m ? m1_arready : m0_arready;
    end while (!ready);
    @(negedge clk);
    if (m) begin
      m1_arvalid = 1'b0;
    end else begin
      m0_arvalid = 1'b0;
    end
  endtask

  task automatic wait_drained();
    while (m0_exp.size() + m1_exp.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic idle_outputs();
    cur_test = "idle";
    repeat (4) begin
      @(posedge clk);
      compare_logic(cur_test, "m0_rvalid", 1'b0, m0_rvalid);
      compare_logic(cur_test, "m1_rvalid", 1'b0, m1_rvalid);
      compare_logic(cur_test, "s0_arvalid", 1'b0, s0_arvalid);
      compare_logic(cur_test, "s1_arvalid", 1'b0, s1_arvalid);
    end
    @(negedge clk);
  endtask

  task automatic single_read();
    cur_test = "single_s0";
    push_expected(1'b0, 4'h6, S0_BASE, 4'd0, S0_KEY, 1'b0);
    send_ar(1'b0, 4'h6, S0_BASE, 4'd0);
    wait_drained();
  endtask

  task automatic burst_read(input string name);
    cur_test = name;
    push_expected(1'b1, 4'h5, S1_BASE + 32'h100, 4'd7, S1_KEY, 1'b0);
    send_ar(1'b1, 4'h5, S1_BASE + 32'h100, 4'd7);
    wait_drained();
  endtask

  task automatic concurrent_reads(input string name);
    cur_test = name;
    push_expected(1'b0, 4'h3, S0_BASE + 32'h200, 4'd7, S0_KEY, 1'b0);
    push_expected(1'b1, 4'hA, S1_BASE + 32'h400, 4'd7, S1_KEY, 1'b0);
    fork
      send_ar(1'b0, 4'h3, S0_BASE + 32'h200, 4'd7);
      send_ar(1'b1, 4'hA, S1_BASE + 32'h400, 4'd7);
    join
    wait_drained();
  endtask

  task automatic unmapped_read();
    cur_test = "unmapped";
    push_expected(1'b1, 4'hC, 32'h0005_0040, 4'd3, 32'h0, 1'b1);
    send_ar(1'b1, 4'hC, 32'h0005_0040, 4'd3);
    wait_drained();
  endtask

  initial begin
    repeat (3 + WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the bursts did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    rstn       = 1'b0;
    m0_ar      = '0;
    m1_ar      = '0;
    m0_arvalid = 1'b0;
    m1_arvalid = 1'b0;
    rand_mode  = 1'b0;
    cur_test   = "reset";
    repeat (3) @(negedge clk);
    rstn = 1'b1;
    idle_outputs();
    single_read();
    burst_read("burst_s1");
    concurrent_reads("concurrent");
    unmapped_read();
    rand_mode = 1'b1;
    burst_read("burst_s1_backpressure");
    concurrent_reads("concurrent_backpressure");
    rand_mode = 1'b0;
    repeat (10) @(negedge clk);
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: list.f
verilog/axi_pkg.sv
verilog/ar_router.sv
verilog/r_router.sv
verilog/decerr_slave.sv
verilog/axi_read_bus.sv
testbench/tb_axi_slave_model.sv
testbench/tb_axi_read_bus.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_read_bus -f list.f -o sim_axi_read_bus

./obj_dir/sim_axi_read_bus | tee sim.log

if grep -q "^RESULT: PASS$" sim.log; then
  exit 0
else
  exit 1
fi
